// File: list.f
+incdir+rtl
rtl/csi2_pkg.sv
rtl/pixel_pkg.sv
rtl/csi2_stream_if.sv
rtl/csi2_stream_slice.sv
rtl/csi2_payload_counter.sv
rtl/csi2_header_fsm.sv
rtl/csi2_raw10_unpack.sv
rtl/csi2_rx_top.sv
test/csi2_rx_asserts.sv
test/csi2_rx_tb.sv

// File: rtl/csi2_config.svh
`ifndef CSI2_CONFIG_SVH
`define CSI2_CONFIG_SVH

// the receive path only accepts long packets on this channel.
`define CSI2_VIRTUAL_CHANNEL 2'd0

`define CSI2_DT_RAW10        6'h2b
`define CSI2_DT_FRAME_START  6'h00
`define CSI2_DT_FRAME_END    6'h01

`define CSI2_WORD_BITS       16  // two PHY lanes, one byte each.
`define CSI2_PIXEL_BITS      10
`define CSI2_PIXELS_PER_BEAT 4

`endif

// File: rtl/csi2_header_fsm.sv
`timescale 1ns/10ps
`include "csi2_config.svh"

module csi2_header_fsm (
    input  logic          s_axi4s,
    input  logic          rst,
    csi2_stream_if.sink   word_in,
    csi2_stream_if.source payload,
    input  logic          frame_start_taken,
    output logic          frame_start_pending,
    output logic          len_error
);
    import csi2_pkg::*;

    typedef enum logic [2:0] {
        HEADER_LO,
        HEADER_HI,
        PAYLOAD,
        CRC,
        DISCARD
    } state_e;

    state_e         state;
    logic [15:0]    header_lo;
    packet_header_t header;
    logic           in_fire;
    logic           in_last;
    logic           pay_word;
    logic           crc_word;
    logic           vc_match;
    logic           is_raw10;
    logic           load;
    logic           step;
    logic           last_word;
    logic           busy;

    // the header is complete once the second word is on the bus.
    assign header = {header_lo[7:0], word_in.payload.data[7:0], header_lo[15:8]};

    assign vc_match = (header.vc == `CSI2_VIRTUAL_CHANNEL);
    assign is_raw10 = vc_match && (header.data_type == DT_RAW10);

    // a zero length line falls straight through to its CRC word.
    assign pay_word = (state == PAYLOAD) && busy;
    assign crc_word = (state == CRC) || ((state == PAYLOAD) && !busy);

    // ==================================================================
    // steering
    // ==================================================================

    assign word_in.ready   = pay_word ? payload.ready : 1'b1;  // drops never stall.
    assign in_fire         = word_in.valid && word_in.ready;
    assign in_last         = word_in.payload.last;
    assign payload.valid   = word_in.valid && pay_word;
    assign payload.payload = {word_in.payload.data, in_last || last_word};

    assign load = in_fire && (state == HEADER_HI) && is_raw10;
    assign step = in_fire && pay_word;

    csi2_payload_counter i_payload_counter (
        .s_axi4s    (s_axi4s),
        .rst        (rst),
        .load       (load),
        .load_words (header.word_count[15:1]),
        .step       (step),
        .last_word  (last_word),
        .busy       (busy)
    );

    always_ff @(posedge s_axi4s) begin
        if (in_fire && (state == HEADER_LO)) begin
            header_lo <= word_in.payload.data;
        end
    end

    // ==================================================================
    // packet state
    // ==================================================================

    always_ff @(posedge s_axi4s) begin
        if (rst) begin
            state               <= HEADER_LO;
            frame_start_pending <= 1'b0;
            len_error           <= 1'b0;
        end else begin
            len_error <= 1'b0;
            if (frame_start_taken) begin
                frame_start_pending <= 1'b0;
            end
            if (in_fire) begin
                case (state)
                    HEADER_LO: begin
                        if (!in_last) begin
                            state <= HEADER_HI;
                        end
                    end
                    HEADER_HI: begin
                        if (is_short_packet(header.data_type) && vc_match &&
                            header.data_type == DT_FRAME_START) begin
                            frame_start_pending <= 1'b1;
                        end
                        if (in_last) begin
                            state <= HEADER_LO;
                        end else if (is_raw10) begin
                            state <= PAYLOAD;
                        end else begin
                            state <= DISCARD;  // other types and channels.
                        end
                    end
                    PAYLOAD, CRC: begin
                        if (crc_word) begin
                            len_error <= !in_last;  // payload ran long.
                            state     <= in_last ? HEADER_LO : DISCARD;
                        end else if (in_last) begin
                            len_error <= 1'b1;
                            state     <= HEADER_LO;
                        end else if (last_word) begin
                            state <= CRC;
                        end
                    end
                    default: begin
                        if (in_last) begin
                            state <= HEADER_LO;
                        end
                    end
                endcase
            end
        end
    end

endmodule

// File: rtl/csi2_payload_counter.sv
`timescale 1ns/10ps

module csi2_payload_counter (
    input  logic        s_axi4s,
    input  logic        rst,
    input  logic        load,
    input  logic [14:0] load_words,
    input  logic        step,
    output logic        last_word,
    output logic        busy
);
    logic [14:0] count;

    // ==================================================================
    // words left in the current long packet
    // ==================================================================

    always_ff @(posedge s_axi4s) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= load_words;
        end else if (step && busy) begin
            count <= count - 15'd1;
        end
    end

    // the word that takes the count to zero closes the line.
    assign last_word = (count == 15'd1);
    assign busy      = (count != '0);

endmodule

// File: rtl/csi2_pkg.sv
`include "csi2_config.svh"

package csi2_pkg;

    // ==================================================================
    // packet framing
    // ==================================================================

    // only these codes are acted on. any other value is dropped.
    typedef enum logic [5:0] {
        DT_FRAME_START = `CSI2_DT_FRAME_START,
        DT_FRAME_END   = `CSI2_DT_FRAME_END,
        DT_RAW10       = `CSI2_DT_RAW10
    } data_type_e;

    typedef struct packed {
        logic [1:0]  vc;
        logic [5:0]  data_type;
        logic [15:0] word_count;  // in bytes for long packets.
    } packet_header_t;

    // codes 0x00 to 0x0f are short packets with no payload and no CRC.
    function automatic logic is_short_packet(logic [5:0] data_type);
        return data_type < 6'h10;
    endfunction

endpackage

// File: rtl/csi2_raw10_unpack.sv
`timescale 1ns/10ps
`include "csi2_config.svh"

module csi2_raw10_unpack (
    input  logic          s_axi4s,
    input  logic          rst,
    csi2_stream_if.sink   payload,
    input  logic          frame_start_pending,
    output logic          frame_start_taken,
    csi2_stream_if.source pixels
);
    localparam int PB = `CSI2_PIXEL_BITS;
    localparam int PPB = `CSI2_PIXELS_PER_BEAT;

    logic [2:0]                   phase;
    logic [4:0][15:0]             group_words;
    logic [9:0][7:0]              group_bytes;
    logic                         st0_user;
    logic                         st0_last;
    logic                         st0_valid;
    logic                         in_fire;
    logic                         group_end;
    logic [2*PPB-1:0][PB-1:0]     st1_pix;
    logic                         st1_user;
    logic                         st1_last;
    logic                         st1_valid;
    logic                         st1_adv;
    logic [1:0][PPB-1:0][PB-1:0]  st2_pix;
    logic                         st2_user;
    logic                         st2_last;
    logic                         st2_valid;
    logic                         st2_half;
    logic                         st2_take;

    // ==================================================================
    // stage 0, gather five words
    // ==================================================================

    assign payload.ready     = !st0_valid || st1_adv;
    assign in_fire           = payload.valid && payload.ready;
    assign group_end         = (phase == 3'd4) || payload.payload.last;
    assign frame_start_taken = in_fire && (phase == 3'd0);
    assign group_bytes       = group_words;

    always_ff @(posedge s_axi4s) begin
        if (rst) begin
            phase     <= '0;
            st0_valid <= 1'b0;
        end else begin
            if (st1_adv) begin
                st0_valid <= 1'b0;
            end
            if (in_fire) begin
                phase <= group_end ? 3'd0 : phase + 3'd1;
                if (group_end) begin
                    st0_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge s_axi4s) begin
        if (in_fire) begin
            group_words[phase] <= payload.payload.data;
            st0_last           <= payload.payload.last;
            if (phase == 3'd0) begin
                st0_user <= frame_start_pending;
            end
        end
    end

    // ==================================================================
    // stage 1, rebuild eight pixels
    // ==================================================================

    assign st1_adv = !st1_valid || st2_take;

    always_ff @(posedge s_axi4s) begin
        if (rst) begin
            st1_valid <= 1'b0;
        end else if (st1_adv) begin
            st1_valid <= st0_valid;
        end
    end

    // byte 4 and byte 9 carry the low bit pairs, lowest pair first.
    always_ff @(posedge s_axi4s) begin
        if (st1_adv) begin
            for (int i = 0; i < PPB; i++) begin
                st1_pix[i]       <= {group_bytes[i], group_bytes[4][2*i +: 2]};
                st1_pix[i + PPB] <= {group_bytes[i + 5], group_bytes[9][2*i +: 2]};
            end
            st1_user <= st0_user;
            st1_last <= st0_last;
        end
    end

    // ==================================================================
    // stage 2, two beats per group
    // ==================================================================

    assign st2_take = !st2_valid || (st2_half && pixels.ready);

    always_ff @(posedge s_axi4s) begin
        if (rst) begin
            st2_valid <= 1'b0;
            st2_half  <= 1'b0;
        end else if (st2_take) begin
            st2_valid <= st1_valid;
            st2_half  <= 1'b0;
        end else if (pixels.ready) begin
            st2_half <= 1'b1;
        end
    end

    always_ff @(posedge s_axi4s) begin
        if (st2_take && st1_valid) begin
            st2_pix  <= st1_pix;
            st2_user <= st1_user;
            st2_last <= st1_last;
        end
    end

    assign pixels.valid   = st2_valid;
    assign pixels.payload = {st2_pix[st2_half], st2_user && !st2_half, st2_last && st2_half};

endmodule

// File: rtl/csi2_rx_top.sv
`timescale 1ns/10ps
`include "csi2_config.svh"

module csi2_rx_top (
    input  logic                                            s_axi4s,
    input  logic                                            rst,
    input  logic [`CSI2_WORD_BITS-1:0]                      s_tdata,
    input  logic                                            s_tlast,
    input  logic                                            s_tvalid,
    output logic                                            s_tready,
    output logic [`CSI2_PIXELS_PER_BEAT*`CSI2_PIXEL_BITS-1:0] m_tdata,
    output logic                                            m_tuser,
    output logic                                            m_tlast,
    output logic                                            m_tvalid,
    input  logic                                            m_tready,
    output logic                                            len_error
);
    import pixel_pkg::*;

    logic frame_start_pending;
    logic frame_start_taken;

    csi2_stream_if #(.payload_t(word_beat_t))  s_stream ();
    csi2_stream_if #(.payload_t(word_beat_t))  word_in ();
    csi2_stream_if #(.payload_t(word_beat_t))  payload ();
    csi2_stream_if #(.payload_t(pixel_beat_t)) pixels ();
    csi2_stream_if #(.payload_t(pixel_beat_t)) m_stream ();

    // plain ports to and from the beat structs.
    assign s_stream.valid   = s_tvalid;
    assign s_stream.payload = {s_tdata, s_tlast};
    assign s_tready         = s_stream.ready;

    assign m_tdata        = m_stream.payload.pixels;
    assign m_tuser        = m_stream.payload.user;
    assign m_tlast        = m_stream.payload.last;
    assign m_tvalid       = m_stream.valid;
    assign m_stream.ready = m_tready;

    csi2_stream_slice #(.payload_t(word_beat_t)) i_in_slice (
        .s_axi4s (s_axi4s),
        .rst     (rst),
        .in      (s_stream.sink),
        .out     (word_in.source)
    );

    csi2_header_fsm i_header_fsm (
        .s_axi4s             (s_axi4s),
        .rst                 (rst),
        .word_in             (word_in.sink),
        .payload             (payload.source),
        .frame_start_taken   (frame_start_taken),
        .frame_start_pending (frame_start_pending),
        .len_error           (len_error)
    );

    csi2_raw10_unpack i_raw10_unpack (
        .s_axi4s             (s_axi4s),
        .rst                 (rst),
        .payload             (payload.sink),
        .frame_start_pending (frame_start_pending),
        .frame_start_taken   (frame_start_taken),
        .pixels              (pixels.source)
    );

    csi2_stream_slice #(.payload_t(pixel_beat_t)) i_out_slice (
        .s_axi4s (s_axi4s),
        .rst     (rst),
        .in      (pixels.sink),
        .out     (m_stream.source)
    );

endmodule

// File: rtl/csi2_stream_if.sv
`timescale 1ns/10ps

interface csi2_stream_if #(
    parameter type payload_t = logic
);
    logic     valid;
    logic     ready;
    payload_t payload;

    // payload is held with valid until the beat transfers.
    modport source (
        output valid,
        output payload,
        input  ready
    );

    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface

// File: rtl/csi2_stream_slice.sv
`timescale 1ns/10ps

module csi2_stream_slice #(
    parameter type payload_t = logic
) (
    input  logic          s_axi4s,
    input  logic          rst,
    csi2_stream_if.sink   in,
    csi2_stream_if.source out
);
    logic     main_valid;
    logic     skid_valid;
    logic     ready_q;
    logic     in_fire;
    logic     main_free;
    payload_t main_data;
    payload_t skid_data;

    assign in_fire   = in.valid && ready_q;
    assign main_free = !main_valid || out.ready;

    always_ff @(posedge s_axi4s) begin
        if (rst) begin
            main_valid <= 1'b0;
            skid_valid <= 1'b0;
            ready_q    <= 1'b0;
        end else begin
            if (main_free) begin
                main_valid <= skid_valid || in_fire;
                skid_valid <= 1'b0;
            end else if (in_fire) begin
                skid_valid <= 1'b1;  // output stalled, park the word.
            end
            ready_q <= !(!main_free && (skid_valid || in_fire));
        end
    end

    always_ff @(posedge s_axi4s) begin
        if (main_free) begin
            main_data <= skid_valid ? skid_data : in.payload;
        end else if (in_fire) begin
            skid_data <= in.payload;
        end
    end

    assign in.ready    = ready_q;
    assign out.valid   = main_valid;
    assign out.payload = main_data;

endmodule

// File: rtl/pixel_pkg.sv
`include "csi2_config.svh"

package pixel_pkg;

    // ==================================================================
    // stream beats
    // ==================================================================

    // merged PHY word, byte 0 of the pair in the low half.
    typedef struct packed {
        logic [`CSI2_WORD_BITS-1:0] data;
        logic                       last;
    } word_beat_t;

    // pixel 0 of the beat sits in the lowest bits.
    typedef struct packed {
        logic [`CSI2_PIXELS_PER_BEAT-1:0][`CSI2_PIXEL_BITS-1:0] pixels;
        logic                                                   user;
        logic                                                   last;
    } pixel_beat_t;

endpackage

// File: test/csi2_rx_asserts.sv
`timescale 1ns/10ps
`include "csi2_config.svh"

module csi2_rx_asserts (
    input logic                                              s_axi4s,
    input logic                                              rst,
    input logic [`CSI2_PIXELS_PER_BEAT*`CSI2_PIXEL_BITS-1:0] m_tdata,
    input logic                                              m_tvalid,
    input logic                                              m_tready,
    input logic                                              len_error
);
    int failures = 0;  // counts every failed property.

    // a stalled beat stays on the bus unchanged.
    hold_on_stall: assert property (@(posedge s_axi4s) disable iff (rst)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata))
    else begin
        failures++;
        $error("output beat changed or vanished while m_tready was low");
    end

    single_len_error: assert property (@(posedge s_axi4s) disable iff (rst)
        len_error |=> !len_error)
    else begin
        failures++;
        $error("len_error stayed high for two cycles");
    end

    quiet_after_reset: assert property (@(posedge s_axi4s) rst |=> !m_tvalid)
    else begin
        failures++;
        $error("m_tvalid was high in the cycle after reset");
    end

endmodule

// File: test/csi2_rx_tb.sv
`timescale 1ns/10ps
`include "csi2_config.svh"

module csi2_rx_tb;

    typedef struct packed {
        logic [39:0] data;
        logic        user;
        logic        last;
    } beat_t;

    logic        s_axi4s;
    logic        rst;
    logic [15:0] s_tdata;
    logic        s_tlast;
    logic        s_tvalid;
    logic        s_tready;
    logic [39:0] m_tdata;
    logic        m_tuser;
    logic        m_tlast;
    logic        m_tvalid;
    logic        m_tready;
    logic        len_error;

    logic [15:0] word_data [$];
    logic        word_last [$];
    logic [7:0]  line_bytes [$];
    beat_t       expected_beats [$];
    logic        fs_pending = 1'b0;
    logic        input_done = 1'b0;
    int          exp_len_errors = 0;
    int          len_error_count = 0;
    int          mismatch_errors = 0;
    int          other_errors = 0;
    int          assert_failures = 0;
    int          cycle_count = 0;
    int          cycle_limit = 1000000;
    int          stall_left = 0;

    csi2_rx_top i_csi2_rx_top (
        .s_axi4s   (s_axi4s),
        .rst       (rst),
        .s_tdata   (s_tdata),
        .s_tlast   (s_tlast),
        .s_tvalid  (s_tvalid),
        .s_tready  (s_tready),
        .m_tdata   (m_tdata),
        .m_tuser   (m_tuser),
        .m_tlast   (m_tlast),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready),
        .len_error (len_error)
    );

    bind csi2_rx_top csi2_rx_asserts i_csi2_rx_asserts (
        .s_axi4s   (s_axi4s),
        .rst       (rst),
        .m_tdata   (m_tdata),
        .m_tvalid  (m_tvalid),
        .m_tready  (m_tready),
        .len_error (len_error)
    );

    always #2 s_axi4s = ~s_axi4s;

    // ======================================================================
    // packet generator and reference model
    // ======================================================================

    task automatic push_word(input logic [15:0] data);
        word_data.push_back(data);
        word_last.push_back(1'b0);
    endtask

    // pixel 0 of a beat sits in the lowest ten bits.
    task automatic expect_line();
        logic [9:0] pix [8];
        logic [7:0] low_a;
        logic [7:0] low_b;
        beat_t      beat;
        int         base;
        int         groups;
        groups = line_bytes.size() / 10;
        for (int g = 0; g < groups; g++) begin
            base  = 10 * g;
            low_a = line_bytes[base + 4];
            low_b = line_bytes[base + 9];
            for (int i = 0; i < 4; i++) begin
                pix[i]     = {line_bytes[base + i], low_a[2*i +: 2]};
                pix[i + 4] = {line_bytes[base + 5 + i], low_b[2*i +: 2]};
            end
            beat.data = {pix[3], pix[2], pix[1], pix[0]};
            beat.user = fs_pending && (g == 0);
            beat.last = 1'b0;
            expected_beats.push_back(beat);
            beat.data = {pix[7], pix[6], pix[5], pix[4]};
            beat.user = 1'b0;
            beat.last = (g == groups - 1);
            expected_beats.push_back(beat);
        end
        fs_pending = 1'b0;  // only the first line of a frame carries user.
    endtask

    task automatic add_short_packet(input logic [1:0] vc, input logic [5:0] dt);
        logic [15:0] field;
        field = 16'($urandom_range(0, 65535));
        push_word({field[7:0], vc, dt});
        push_word({8'($urandom_range(0, 255)), field[15:8]});
        word_last[word_last.size() - 1] = 1'b1;
        if (vc == `CSI2_VIRTUAL_CHANNEL && dt == `CSI2_DT_FRAME_START) begin
            fs_pending = 1'b1;
        end
    endtask

    // a sent count below wc cuts the packet short. extra adds words after the CRC.
    task automatic add_long_packet(input logic [1:0] vc, input logic [5:0] dt, input int wc,
                                   input int sent, input int extra);
        logic [7:0] b0;
        logic [7:0] b1;
        line_bytes.delete();
        push_word({wc[7:0], vc, dt});
        push_word({8'($urandom_range(0, 255)), wc[15:8]});
        for (int i = 0; i < sent; i += 2) begin
            b0 = 8'($urandom_range(0, 255));
            b1 = 8'($urandom_range(0, 255));
            line_bytes.push_back(b0);
            line_bytes.push_back(b1);
            push_word({b1, b0});
        end
        if (sent == wc) begin
            push_word(16'($urandom_range(0, 65535)));  // CRC word.
        end
        repeat (extra) push_word(16'($urandom_range(0, 65535)));
        word_last[word_last.size() - 1] = 1'b1;
        if (sent != wc || extra != 0) begin
            exp_len_errors++;
        end
        if (vc == `CSI2_VIRTUAL_CHANNEL && dt == `CSI2_DT_RAW10) begin
            expect_line();
        end
    endtask

    task automatic build_packets();
        int         wc;
        logic [5:0] other_dt;
        add_long_packet(2'd0, `CSI2_DT_RAW10, 20, 20, 0);  // before any frame start.
        for (int f = 0; f < 8; f++) begin
            add_short_packet(2'd0, `CSI2_DT_FRAME_START);
            repeat (6) begin
                wc = 10 * $urandom_range(1, 8);
                other_dt = ($urandom_range(0, 1) == 0) ? 6'h2a : 6'h12;
                case ($urandom_range(0, 9))
                    0, 1, 2, 3, 4: add_long_packet(2'd0, `CSI2_DT_RAW10, wc, wc, 0);
                    5: add_long_packet(2'($urandom_range(0, 3)), other_dt, wc, wc, 0);
                    6: add_long_packet(2'($urandom_range(1, 3)), `CSI2_DT_RAW10, wc, wc, 0);
                    7: add_short_packet(2'($urandom_range(0, 3)), 6'($urandom_range(2, 15)));
                    8: begin
                        wc = 10 * $urandom_range(2, 8);
                        add_long_packet(2'd0, `CSI2_DT_RAW10, wc,
                                        wc - 10 * $urandom_range(1, wc / 10 - 1), 0);
                    end
                    default: add_long_packet(2'd0, `CSI2_DT_RAW10, wc, wc,
                                             $urandom_range(1, 3));
                endcase
            end
            add_short_packet(2'd0, `CSI2_DT_FRAME_END);
        end
    endtask

    // ======================================================================
    // drivers and monitor
    // ======================================================================

    task automatic drive_input();
        int   idx;
        logic fire;
        idx = 0;
        while (idx < word_data.size()) begin
            @(negedge s_axi4s);
            fire = s_tvalid && s_tready;  // transfer at the coming edge.
            @(posedge s_axi4s);
            #1;
            if (fire) begin
                idx++;
            end
            if (idx >= word_data.size()) begin
                s_tvalid = 1'b0;
            end else if (fire || !s_tvalid) begin
                s_tvalid = ($urandom_range(0, 3) != 0);
                s_tdata  = word_data[idx];
                s_tlast  = word_last[idx];
            end
        end
        input_done = 1'b1;
    endtask

    // now and then a long stall backs the pipeline up until s_tready falls.
    always @(posedge s_axi4s) begin
        #1;
        if (stall_left > 0) begin
            stall_left--;
            m_tready = 1'b0;
        end else if ($urandom_range(0, 47) == 0) begin
            stall_left = $urandom_range(8, 40);
            m_tready   = 1'b0;
        end else begin
            m_tready = ($urandom_range(0, 3) != 0);
        end
    end

    task automatic check_beat();
        beat_t exp;
        assert (expected_beats.size() > 0) else begin
            other_errors++;
            $display("unexpected output beat at %0t with no line left in the model", $time);
        end
        if (expected_beats.size() > 0) begin
            exp = expected_beats.pop_front();
            assert (m_tdata === exp.data) else begin
                mismatch_errors++;
                $display("mismatch at %0t: m_tdata = %h, expected %h", $time, m_tdata, exp.data);
            end
            assert (m_tuser === exp.user) else begin
                mismatch_errors++;
                $display("mismatch at %0t: m_tuser = %b, expected %b", $time, m_tuser, exp.user);
            end
            assert (m_tlast === exp.last) else begin
                mismatch_errors++;
                $display("mismatch at %0t: m_tlast = %b, expected %b", $time, m_tlast, exp.last);
            end
        end
    endtask

    always @(negedge s_axi4s) begin
        if (!rst) begin
            if (len_error) begin
                len_error_count++;
            end
            if (m_tvalid && m_tready) begin
                check_beat();
            end
        end
    end

    always @(posedge s_axi4s) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("timeout after %0d cycles, %0d beats never arrived",
                     cycle_count, expected_beats.size());
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'h5fe98f82));
        s_axi4s  = 1'b0;
        rst      = 1'b1;
        s_tdata  = '0;
        s_tlast  = 1'b0;
        s_tvalid = 1'b0;
        m_tready = 1'b0;
        build_packets();
        cycle_limit = 8 * word_data.size() + 200;
        repeat (4) @(posedge s_axi4s);
        #1;
        rst = 1'b0;
        fork
            drive_input();
        join_none
        while (!input_done || expected_beats.size() != 0) begin
            @(posedge s_axi4s);
        end
        repeat (20) @(posedge s_axi4s);  // room for stray beats to show up.
        assert (len_error_count == exp_len_errors) else begin
            mismatch_errors++;
            $display("mismatch at %0t: len_error pulse count = %0d, expected %0d",
                     $time, len_error_count, exp_len_errors);
        end
        assert_failures = i_csi2_rx_top.i_csi2_rx_asserts.failures;
        $display("errors: %0d mismatches, %0d other, %0d protocol assertions",
                 mismatch_errors, other_errors, assert_failures);
        if (mismatch_errors + other_errors + assert_failures == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule
